//--- common/cce_pkg.sv
// Shared types for the CCE register stage
// Directory state arrives per request set, so no directory storage is modeled
package cce_pkg;

  localparam int NUM_LCE     = 4;
  localparam int LG_NUM_LCE  = $clog2(NUM_LCE);
  localparam int LCE_ASSOC   = 4;
  localparam int LG_ASSOC    = $clog2(LCE_ASSOC);
  localparam int LCE_SETS    = 64;
  localparam int LG_SETS     = $clog2(LCE_SETS);
  localparam int BLOCK_BYTES = 64;
  localparam int LG_BLOCK    = $clog2(BLOCK_BYTES);
  localparam int PADDR_W     = 32;
  localparam int TAG_W       = PADDR_W - LG_SETS - LG_BLOCK;
  localparam int NUM_GPR     = 8;
  localparam int LG_NUM_GPR  = $clog2(NUM_GPR);
  localparam int GPR_W       = 16;
  localparam int NC_DATA_W   = 64;
  localparam int NUM_FLAGS   = 14;
  localparam int IMM_W       = 15;

  typedef enum logic [2:0] {
    e_coh_i = 3'd0,
    e_coh_s = 3'd1,
    e_coh_e = 3'd2,
    e_coh_m = 3'd3,
    e_coh_o = 3'd4
  } coh_state_e;

  typedef enum logic [1:0] {
    e_req_rd    = 2'd0,
    e_req_wr    = 2'd1,
    e_req_uc_rd = 2'd2,
    e_req_uc_wr = 2'd3
  } lce_req_type_e;

  typedef enum logic [1:0] {
    e_uc_size_1 = 2'd0,
    e_uc_size_2 = 2'd1,
    e_uc_size_4 = 2'd2,
    e_uc_size_8 = 2'd3
  } uc_size_e;

  // Bit positions in mshr_s.flags
  typedef enum logic [3:0] {
    e_flag_rqf, e_flag_ucf, e_flag_nerf, e_flag_ldf, e_flag_nwbf,
    e_flag_tf, e_flag_pf, e_flag_rf, e_flag_uf, e_flag_if,
    e_flag_cf, e_flag_cef, e_flag_cof, e_flag_lef
  } flag_e;

  typedef enum logic [3:0] {
    e_op_add, e_op_sub, e_op_inc, e_op_and, e_op_or,
    e_op_movi, e_op_movr, e_op_rdresp, e_op_clm, e_op_ldreq,
    e_op_gad, e_op_sflag, e_op_ldnwb, e_op_movncs
  } opcode_e;

  // Where a flag write takes its value from
  typedef enum logic [1:0] {
    e_fsrc_req   = 2'd0,
    e_fsrc_logic = 2'd1,
    e_fsrc_imm   = 2'd2
  } flag_src_e;

  // Flags loaded by ldreq and by gad
  localparam logic [NUM_FLAGS-1:0] REQ_FLAG_MASK =
    (NUM_FLAGS'(1) << e_flag_rqf) | (NUM_FLAGS'(1) << e_flag_ucf)
    | (NUM_FLAGS'(1) << e_flag_nerf) | (NUM_FLAGS'(1) << e_flag_ldf);
  localparam logic [NUM_FLAGS-1:0] GAD_FLAG_MASK =
    (NUM_FLAGS'(1) << e_flag_tf) | (NUM_FLAGS'(1) << e_flag_rf)
    | (NUM_FLAGS'(1) << e_flag_uf) | (NUM_FLAGS'(1) << e_flag_if)
    | (NUM_FLAGS'(1) << e_flag_cf) | (NUM_FLAGS'(1) << e_flag_cef)
    | (NUM_FLAGS'(1) << e_flag_cof) | (NUM_FLAGS'(1) << e_flag_lef);

  typedef logic [NUM_GPR-1:0][GPR_W-1:0] gpr_file_t;

  // 32-bit microinstruction, immediate in the low bits
  typedef struct packed {
    opcode_e               opcode;
    logic [LG_NUM_GPR-1:0] dst;
    logic [LG_NUM_GPR-1:0] src_a;
    logic [LG_NUM_GPR-1:0] src_b;
    logic [3:0]            flag;
    logic [IMM_W-1:0]      imm;
  } cce_inst_s;

  typedef struct packed {
    opcode_e                         alu_op;
    logic [LG_NUM_GPR-1:0]           src_a;
    logic [LG_NUM_GPR-1:0]           src_b;
    logic [NUM_GPR-1:0]              gpr_w_mask;
    logic                            alu_w_v;
    logic                            mov_w_v;
    logic                            resp_w_v;
    logic                            mov_imm_sel;
    logic [IMM_W-1:0]                imm;
    logic                            mshr_clear;
    logic                            req_w_v;
    logic                            way_w_v;
    logic                            lru_way_w_v;
    logic                            transfer_w_v;
    logic                            nc_size_w_v;
    logic                            nc_data_w_v;
    logic [NUM_FLAGS-1:0]            flag_w_mask;
    flag_src_e [NUM_FLAGS-1:0]       flag_sel;
    logic                            next_state_w_v;
    logic                            dir_v;
  } decoded_inst_s;

  typedef struct packed {
    logic [LG_NUM_LCE-1:0] src_id;
    lce_req_type_e         msg_type;
    logic [PADDR_W-1:0]    addr;
    logic [LG_ASSOC-1:0]   lru_way_id;
    logic                  non_exclusive;
    logic                  lru_dirty;
    uc_size_e              uc_size;
    logic [NC_DATA_W-1:0]  data;
  } lce_req_s;

  typedef struct packed {
    coh_state_e [NUM_LCE-1:0]            state;
    logic [NUM_LCE-1:0][LG_ASSOC-1:0]    way;
    logic [TAG_W-1:0]                    lru_tag;
    coh_state_e                          lru_state;
  } dir_info_s;

  typedef struct packed {
    logic [LG_ASSOC-1:0]   way_id;
    logic [LG_NUM_LCE-1:0] tr_lce_id;
    logic [LG_ASSOC-1:0]   tr_way_id;
    logic                  tf;
    logic                  rf;
    logic                  uf;
    logic                  if_flag;
    logic                  cf;
    logic                  cef;
    logic                  cof;
    logic                  lef;
  } dir_flags_s;

  typedef struct packed {
    logic [LG_NUM_LCE-1:0] lce_id;
    logic [PADDR_W-1:0]    paddr;
    logic [LG_ASSOC-1:0]   way_id;
    logic [LG_ASSOC-1:0]   lru_way_id;
    logic [LG_NUM_LCE-1:0] tr_lce_id;
    logic [LG_ASSOC-1:0]   tr_way_id;
    logic [NUM_FLAGS-1:0]  flags;
    coh_state_e            next_coh_state;
    uc_size_e              uc_req_size;
    logic [PADDR_W-1:0]    lru_paddr;
  } mshr_s;

endpackage

//--- design/cce_inst_decode.sv
// Microinstruction decoder, purely combinational
// Every write enable is low unless inst_v_i is high
module cce_inst_decode
  import cce_pkg::*;
  (
  input  logic          inst_v_i,
  input  cce_inst_s     inst_i,
  output decoded_inst_s decoded_o
);

  logic [NUM_GPR-1:0] dst_mask;

  assign dst_mask = {{(NUM_GPR-1){1'b0}}, 1'b1} << inst_i.dst;

  always_comb begin
    decoded_o = '0;

    // Operand fields pass through regardless of the strobe
    decoded_o.alu_op = inst_i.opcode;
    decoded_o.src_a  = inst_i.src_a;
    decoded_o.src_b  = inst_i.src_b;
    decoded_o.imm    = inst_i.imm;

    if (inst_v_i) begin
      case (inst_i.opcode)
        e_op_add, e_op_sub, e_op_inc, e_op_and, e_op_or: begin
          decoded_o.alu_w_v    = 1'b1;
          decoded_o.gpr_w_mask = dst_mask;
        end
        e_op_movi, e_op_movr: begin
          decoded_o.mov_w_v     = 1'b1;
          decoded_o.mov_imm_sel = (inst_i.opcode == e_op_movi);
          decoded_o.gpr_w_mask  = dst_mask;
        end
        e_op_rdresp: begin
          decoded_o.resp_w_v   = 1'b1;
          decoded_o.gpr_w_mask = dst_mask;
        end
        e_op_clm: begin
          decoded_o.mshr_clear = 1'b1;
        end
        e_op_ldreq: begin
          decoded_o.req_w_v     = 1'b1;
          decoded_o.lru_way_w_v = 1'b1;
          decoded_o.nc_size_w_v = 1'b1;
          decoded_o.nc_data_w_v = 1'b1;
          decoded_o.flag_w_mask = REQ_FLAG_MASK;
          for (int i = 0; i < NUM_FLAGS; i++) begin
            if (REQ_FLAG_MASK[i]) begin
              decoded_o.flag_sel[i] = e_fsrc_req;
            end
          end
        end
        e_op_gad: begin
          decoded_o.way_w_v      = 1'b1;
          decoded_o.transfer_w_v = 1'b1;
          decoded_o.dir_v        = 1'b1;
          decoded_o.flag_w_mask  = GAD_FLAG_MASK;
          for (int i = 0; i < NUM_FLAGS; i++) begin
            if (GAD_FLAG_MASK[i]) begin
              decoded_o.flag_sel[i] = e_fsrc_logic;
            end
          end
        end
        e_op_sflag: begin
          // Indices past the last flag write nothing
          if (inst_i.flag < NUM_FLAGS) begin
            decoded_o.flag_w_mask[inst_i.flag] = 1'b1;
            decoded_o.flag_sel[inst_i.flag]    = e_fsrc_imm;
          end
        end
        e_op_ldnwb: begin
          // Null writeback bit comes from the response side
          decoded_o.flag_w_mask[e_flag_nwbf] = 1'b1;
          decoded_o.flag_sel[e_flag_nwbf]    = e_fsrc_logic;
        end
        e_op_movncs: begin
          decoded_o.next_state_w_v = 1'b1;
        end
        default: begin
          // Undefined opcodes write nothing
        end
      endcase
    end
  end

endmodule

//--- design/cce_alu.sv
// GPR ALU, results wrap at GPR_W bits
// Non-ALU opcodes give a zero result
module cce_alu
  import cce_pkg::*;
  (
  input  decoded_inst_s    decoded_i,
  input  gpr_file_t        gpr_i,
  output logic [GPR_W-1:0] res_o
);

  logic [GPR_W-1:0] op_a;
  logic [GPR_W-1:0] op_b;

  assign op_a = gpr_i[decoded_i.src_a];
  assign op_b = gpr_i[decoded_i.src_b];

  always_comb begin
    case (decoded_i.alu_op)
      e_op_add: res_o = op_a + op_b;
      e_op_sub: res_o = op_a - op_b;
      e_op_inc: res_o = op_a + GPR_W'(1);
      e_op_and: res_o = op_a & op_b;
      e_op_or:  res_o = op_a | op_b;
      default:  res_o = '0;
    endcase
  end

endmodule

//--- design/cce_dir_flags.sv
// Coherence decision flags from the directory state of the request set
// Reads the MSHR as it stood before the current instruction
module cce_dir_flags
  import cce_pkg::*;
  (
  input  mshr_s      mshr_i,
  input  dir_info_s  dir_i,
  output dir_flags_s flags_o
);

  coh_state_e            req_state;
  logic                  is_write;
  logic                  others_cached;
  logic                  others_excl;
  logic                  others_owned;
  logic                  tr_found;
  logic [LG_NUM_LCE-1:0] tr_lce;

  assign req_state = dir_i.state[mshr_i.lce_id];
  assign is_write  = mshr_i.flags[e_flag_rqf];

  // Scan the other LCEs, lowest owner wins the transfer
  always_comb begin
    others_cached = 1'b0;
    others_excl   = 1'b0;
    others_owned  = 1'b0;
    tr_found      = 1'b0;
    tr_lce        = '0;
    for (int i = 0; i < NUM_LCE; i++) begin
      if (LG_NUM_LCE'(i) != mshr_i.lce_id) begin
        others_cached |= (dir_i.state[i] != e_coh_i);
        others_excl   |= (dir_i.state[i] == e_coh_e) || (dir_i.state[i] == e_coh_m);
        others_owned  |= (dir_i.state[i] == e_coh_o);
        if (!tr_found && ((dir_i.state[i] == e_coh_e) || (dir_i.state[i] == e_coh_m)
                          || (dir_i.state[i] == e_coh_o))) begin
          tr_found = 1'b1;
          tr_lce   = LG_NUM_LCE'(i);
        end
      end
    end
  end

  always_comb begin
    flags_o.cf  = others_cached;
    flags_o.cef = others_excl;
    flags_o.cof = others_owned;

    // Uncached requests never transfer a block
    flags_o.tf        = tr_found && !mshr_i.flags[e_flag_ucf];
    flags_o.tr_lce_id = tr_lce;
    flags_o.tr_way_id = tr_found ? dir_i.way[tr_lce] : '0;

    flags_o.uf      = is_write && (req_state == e_coh_s);
    flags_o.if_flag = is_write && others_cached;

    // LRU victim needs writeback only if dirty and the requester misses
    flags_o.rf  = ((dir_i.lru_state == e_coh_m) || (dir_i.lru_state == e_coh_o))
                  && (req_state == e_coh_i);
    flags_o.lef = (dir_i.lru_state == e_coh_e) || (dir_i.lru_state == e_coh_m);

    flags_o.way_id = (req_state != e_coh_i) ? dir_i.way[mshr_i.lce_id] : mshr_i.lru_way_id;
  end

endmodule

//--- cce_reg/cce_reg.sv
// MSHR, GPR file and uncached data register
// Only enabled fields change; clm has priority over all other MSHR writes
module cce_reg
  import cce_pkg::*;
  (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  decoded_inst_s        decoded_i,
  input  lce_req_s             lce_req_i,
  input  logic                 null_wb_i,
  input  lce_req_type_e        resp_type_i,
  input  logic [GPR_W-1:0]     alu_res_i,
  input  dir_flags_s           dir_flags_i,
  input  logic [TAG_W-1:0]     dir_lru_tag_i,
  output mshr_s                mshr_o,
  output gpr_file_t            gpr_o,
  output logic [NC_DATA_W-1:0] nc_data_o
);

  mshr_s                mshr_r;
  mshr_s                mshr_n;
  gpr_file_t            gpr_r;
  logic [NC_DATA_W-1:0] nc_data_r;
  logic [GPR_W-1:0]     gpr_wr_data;
  logic [NUM_FLAGS-1:0] req_flags;
  logic [NUM_FLAGS-1:0] logic_flags;

  assign mshr_o    = mshr_r;
  assign gpr_o     = gpr_r;
  assign nc_data_o = nc_data_r;

  // GPR write value, only one source is enabled per instruction
  always_comb begin
    if (decoded_i.alu_w_v) begin
      gpr_wr_data = alu_res_i;
    end else if (decoded_i.mov_w_v) begin
      gpr_wr_data = decoded_i.mov_imm_sel ? {{(GPR_W-IMM_W){1'b0}}, decoded_i.imm}
                                          : gpr_r[decoded_i.src_a];
    end else if (decoded_i.resp_w_v) begin
      gpr_wr_data = {{(GPR_W-2){1'b0}}, resp_type_i};
    end else begin
      gpr_wr_data = '0;
    end
  end

  // Flag values by source, unused positions stay zero
  always_comb begin
    req_flags                = '0;
    req_flags[e_flag_rqf]    = (lce_req_i.msg_type == e_req_wr)
                               || (lce_req_i.msg_type == e_req_uc_wr);
    req_flags[e_flag_ucf]    = (lce_req_i.msg_type == e_req_uc_rd)
                               || (lce_req_i.msg_type == e_req_uc_wr);
    req_flags[e_flag_nerf]   = lce_req_i.non_exclusive;
    req_flags[e_flag_ldf]    = lce_req_i.lru_dirty;

    logic_flags              = '0;
    logic_flags[e_flag_nwbf] = null_wb_i;
    logic_flags[e_flag_tf]   = dir_flags_i.tf;
    logic_flags[e_flag_rf]   = dir_flags_i.rf;
    logic_flags[e_flag_uf]   = dir_flags_i.uf;
    logic_flags[e_flag_if]   = dir_flags_i.if_flag;
    logic_flags[e_flag_cf]   = dir_flags_i.cf;
    logic_flags[e_flag_cef]  = dir_flags_i.cef;
    logic_flags[e_flag_cof]  = dir_flags_i.cof;
    logic_flags[e_flag_lef]  = dir_flags_i.lef;
  end

  always_comb begin
    mshr_n = mshr_r;

    mshr_n.lce_id      = lce_req_i.src_id;
    mshr_n.paddr       = lce_req_i.addr;
    mshr_n.lru_way_id  = lce_req_i.lru_way_id;
    mshr_n.uc_req_size = lce_req_i.uc_size;
    mshr_n.way_id      = dir_flags_i.way_id;
    mshr_n.tr_lce_id   = dir_flags_i.tr_lce_id;
    mshr_n.tr_way_id   = dir_flags_i.tr_way_id;

    for (int i = 0; i < NUM_FLAGS; i++) begin
      case (decoded_i.flag_sel[i])
        e_fsrc_req:   mshr_n.flags[i] = req_flags[i];
        e_fsrc_logic: mshr_n.flags[i] = logic_flags[i];
        e_fsrc_imm:   mshr_n.flags[i] = decoded_i.imm[0];
        default:      mshr_n.flags[i] = 1'b0;
      endcase
    end

    mshr_n.next_coh_state = coh_state_e'(decoded_i.imm[2:0]);

    // Victim address keeps the set of the current request
    mshr_n.lru_paddr = {dir_lru_tag_i, mshr_r.paddr[LG_BLOCK +: LG_SETS], {LG_BLOCK{1'b0}}};
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mshr_r    <= '0;
      gpr_r     <= '0;
      nc_data_r <= '0;
    end else begin
      if (decoded_i.mshr_clear) begin
        mshr_r <= '0;
      end else begin
        if (decoded_i.req_w_v) begin
          mshr_r.lce_id <= mshr_n.lce_id;
          mshr_r.paddr  <= mshr_n.paddr;
        end
        if (decoded_i.way_w_v) begin
          mshr_r.way_id <= mshr_n.way_id;
        end
        if (decoded_i.lru_way_w_v) begin
          mshr_r.lru_way_id <= mshr_n.lru_way_id;
        end
        if (decoded_i.transfer_w_v) begin
          mshr_r.tr_lce_id <= mshr_n.tr_lce_id;
          mshr_r.tr_way_id <= mshr_n.tr_way_id;
        end
        for (int i = 0; i < NUM_FLAGS; i++) begin
          if (decoded_i.flag_w_mask[i]) begin
            mshr_r.flags[i] <= mshr_n.flags[i];
          end
        end
        if (decoded_i.next_state_w_v) begin
          mshr_r.next_coh_state <= mshr_n.next_coh_state;
        end
        if (decoded_i.nc_size_w_v) begin
          mshr_r.uc_req_size <= mshr_n.uc_req_size;
        end
        if (decoded_i.dir_v) begin
          mshr_r.lru_paddr <= mshr_n.lru_paddr;
        end
      end

      for (int i = 0; i < NUM_GPR; i++) begin
        if (decoded_i.gpr_w_mask[i]) begin
          gpr_r[i] <= gpr_wr_data;
        end
      end

      if (decoded_i.nc_data_w_v) begin
        nc_data_r <= lce_req_i.data;
      end
    end
  end

endmodule

//--- design/cce_top.sv
// CCE register stage: decode, execute and state
// Register outputs change one cycle after the instruction strobe
module cce_top
  import cce_pkg::*;
  (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 inst_v_i,
  input  cce_inst_s            inst_i,
  input  lce_req_s             lce_req_i,
  input  dir_info_s            dir_i,
  input  logic                 null_wb_i,
  input  lce_req_type_e        resp_type_i,
  output mshr_s                mshr_o,
  output gpr_file_t            gpr_o,
  output logic [NC_DATA_W-1:0] nc_data_o
);

  decoded_inst_s    decoded;
  logic [GPR_W-1:0] alu_res;
  dir_flags_s       dir_flags;

  cce_inst_decode i_decode (
    .inst_v_i  (inst_v_i),
    .inst_i    (inst_i),
    .decoded_o (decoded)
  );

  cce_alu i_alu (
    .decoded_i (decoded),
    .gpr_i     (gpr_o),
    .res_o     (alu_res)
  );

  cce_dir_flags i_dir_flags (
    .mshr_i  (mshr_o),
    .dir_i   (dir_i),
    .flags_o (dir_flags)
  );

  cce_reg i_reg (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .decoded_i     (decoded),
    .lce_req_i     (lce_req_i),
    .null_wb_i     (null_wb_i),
    .resp_type_i   (resp_type_i),
    .alu_res_i     (alu_res),
    .dir_flags_i   (dir_flags),
    .dir_lru_tag_i (dir_i.lru_tag),
    .mshr_o        (mshr_o),
    .gpr_o         (gpr_o),
    .nc_data_o     (nc_data_o)
  );

endmodule

//--- sim/cce_model.svh
// Reference model of the CCE register stage, one instruction per call
// Included inside cce_tb after the package import
`ifndef CCE_MODEL_SVH
`define CCE_MODEL_SVH

typedef struct packed {
  mshr_s                mshr;
  gpr_file_t            gpr;
  logic [NC_DATA_W-1:0] nc_data;
} model_state_s;

function automatic bit is_owner_state(coh_state_e s);
  return (s == e_coh_e) || (s == e_coh_m) || (s == e_coh_o);
endfunction

// Directory decision on the MSHR as it stood before the gad
function automatic mshr_s apply_gad(mshr_s m, dir_info_s d);
  mshr_s      nxt;
  coh_state_e own;
  logic       write;
  logic       others_valid;
  logic       others_em;
  logic       others_o;
  logic       found;
  int         tr;
  int         set_idx;
  nxt          = m;
  own          = d.state[m.lce_id];
  write        = m.flags[e_flag_rqf];
  others_valid = 1'b0;
  others_em    = 1'b0;
  others_o     = 1'b0;
  found        = 1'b0;
  tr           = 0;
  set_idx      = int'(m.paddr / BLOCK_BYTES) % LCE_SETS;
  // Scan downward so the last hit is the lowest owner
  for (int i = NUM_LCE - 1; i >= 0; i--) begin
    if (i != int'(m.lce_id)) begin
      others_valid |= (d.state[i] != e_coh_i);
      others_em    |= (d.state[i] inside {e_coh_e, e_coh_m});
      others_o     |= (d.state[i] == e_coh_o);
      if (is_owner_state(d.state[i])) begin
        found = 1'b1;
        tr    = i;
      end
    end
  end
  nxt.flags[e_flag_cf]  = others_valid;
  nxt.flags[e_flag_cef] = others_em;
  nxt.flags[e_flag_cof] = others_o;
  nxt.flags[e_flag_tf]  = found && !m.flags[e_flag_ucf];
  nxt.flags[e_flag_uf]  = write && (own == e_coh_s);
  nxt.flags[e_flag_if]  = write && others_valid;
  nxt.flags[e_flag_rf]  = (d.lru_state inside {e_coh_m, e_coh_o}) && (own == e_coh_i);
  nxt.flags[e_flag_lef] = d.lru_state inside {e_coh_e, e_coh_m};
  nxt.tr_lce_id         = found ? LG_NUM_LCE'(tr) : '0;
  nxt.tr_way_id         = found ? d.way[tr] : '0;
  nxt.way_id            = (own != e_coh_i) ? d.way[m.lce_id] : m.lru_way_id;
  // Tag on top, set index times block size below it
  nxt.lru_paddr         = (PADDR_W'(d.lru_tag) << (PADDR_W - TAG_W))
                          + PADDR_W'(set_idx * BLOCK_BYTES);
  return nxt;
endfunction

function automatic model_state_s cce_step(model_state_s cur, cce_inst_s in, lce_req_s req,
                                          dir_info_s d, logic null_wb, lce_req_type_e resp);
  model_state_s     nxt;
  logic [GPR_W-1:0] a;
  logic [GPR_W-1:0] b;
  nxt = cur;
  a   = cur.gpr[in.src_a];
  b   = cur.gpr[in.src_b];
  case (in.opcode)
    e_op_add:    nxt.gpr[in.dst] = a + b;
    e_op_sub:    nxt.gpr[in.dst] = a - b;
    e_op_inc:    nxt.gpr[in.dst] = a + 16'd1;
    e_op_and:    nxt.gpr[in.dst] = a & b;
    e_op_or:     nxt.gpr[in.dst] = a | b;
    e_op_movi:   nxt.gpr[in.dst] = GPR_W'(in.imm);
    e_op_movr:   nxt.gpr[in.dst] = a;
    e_op_rdresp: nxt.gpr[in.dst] = GPR_W'(resp);
    e_op_clm:    nxt.mshr = '0;
    e_op_ldreq: begin
      nxt.mshr.lce_id           = req.src_id;
      nxt.mshr.paddr            = req.addr;
      nxt.mshr.lru_way_id       = req.lru_way_id;
      nxt.mshr.uc_req_size      = req.uc_size;
      nxt.mshr.flags[e_flag_rqf]  = (req.msg_type inside {e_req_wr, e_req_uc_wr});
      nxt.mshr.flags[e_flag_ucf]  = (req.msg_type inside {e_req_uc_rd, e_req_uc_wr});
      nxt.mshr.flags[e_flag_nerf] = req.non_exclusive;
      nxt.mshr.flags[e_flag_ldf]  = req.lru_dirty;
      nxt.nc_data               = req.data;
    end
    e_op_gad:    nxt.mshr = apply_gad(cur.mshr, d);
    e_op_sflag: begin
      if (int'(in.flag) < NUM_FLAGS) begin
        nxt.mshr.flags[in.flag] = in.imm[0];
      end
    end
    e_op_ldnwb:  nxt.mshr.flags[e_flag_nwbf] = null_wb;
    e_op_movncs: nxt.mshr.next_coh_state = coh_state_e'(in.imm[2:0]);
    default:     nxt = cur;
  endcase
  return nxt;
endfunction

`endif

//--- sim/cce_tb.sv
// Testbench for cce_top, random stimulus against a reference model
// Outputs are compared on every falling edge once reset is released
module cce_tb
  import cce_pkg::*;
  ;
  timeunit 1ns;
  timeprecision 100ps;

  `include "cce_model.svh"

  localparam int DRAIN_LIMIT = 20;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 inst_v;
  cce_inst_s            inst;
  lce_req_s             lce_req;
  dir_info_s            dir;
  logic                 null_wb;
  lce_req_type_e        resp_type;
  mshr_s                mshr;
  gpr_file_t            gpr;
  logic [NC_DATA_W-1:0] nc_data;

  model_state_s exp_state;
  logic         check_due;
  int           strobes_issued  = 0;
  int           strobes_checked = 0;
  int           check_count     = 0;
  int           error_count     = 0;
  int           test_count      = 0;
  int           test_err_mark   = 0;

  always #4 clk = ~clk;

  cce_top i_cce_top (
    .clk_i       (clk),
    .reset_i     (reset),
    .inst_v_i    (inst_v),
    .inst_i      (inst),
    .lce_req_i   (lce_req),
    .dir_i       (dir),
    .null_wb_i   (null_wb),
    .resp_type_i (resp_type),
    .mshr_o      (mshr),
    .gpr_o       (gpr),
    .nc_data_o   (nc_data)
  );

  task automatic check_mshr(mshr_s got, mshr_s exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL t=%0t mshr_o got %h exp %h", $time, got, exp);
    end
  endtask

  task automatic check_gpr(gpr_file_t got, gpr_file_t exp);
    for (int i = 0; i < NUM_GPR; i++) begin
      check_count++;
      if (got[i] !== exp[i]) begin
        error_count++;
        $display("FAIL t=%0t gpr_o[%0d] got %h exp %h", $time, i, got[i], exp[i]);
      end
    end
  endtask

  task automatic check_nc(logic [NC_DATA_W-1:0] got, logic [NC_DATA_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL t=%0t nc_data_o got %h exp %h", $time, got, exp);
    end
  endtask

  // Model follows the DUT's sampling edge
  always @(posedge clk) begin
    if (reset) begin
      exp_state <= '0;
      check_due <= 1'b0;
    end else begin
      check_due <= inst_v;
      if (inst_v) begin
        exp_state <= cce_step(exp_state, inst, lce_req, dir, null_wb, resp_type);
      end
    end
  end

  always @(negedge clk) begin
    if (!reset) begin
      check_mshr(mshr, exp_state.mshr);
      check_gpr(gpr, exp_state.gpr);
      check_nc(nc_data, exp_state.nc_data);
      if (check_due) begin
        strobes_checked++;
      end
    end
  end

  function automatic lce_req_s rand_req();
    lce_req_s r;
    r.src_id        = LG_NUM_LCE'($urandom);
    r.msg_type      = lce_req_type_e'(2'($urandom));
    r.addr          = $urandom;
    r.lru_way_id    = LG_ASSOC'($urandom);
    r.non_exclusive = 1'($urandom);
    r.lru_dirty     = 1'($urandom);
    r.uc_size       = uc_size_e'(2'($urandom));
    r.data          = {$urandom, $urandom};
    return r;
  endfunction

  function automatic dir_info_s rand_dir();
    dir_info_s d;
    for (int i = 0; i < NUM_LCE; i++) begin
      d.state[i] = coh_state_e'(3'($urandom_range(4)));
      d.way[i]   = LG_ASSOC'($urandom);
    end
    d.lru_tag   = TAG_W'($urandom);
    d.lru_state = coh_state_e'(3'($urandom_range(4)));
    return d;
  endfunction

  function automatic cce_inst_s make_inst(opcode_e op);
    cce_inst_s i;
    i.opcode = op;
    i.dst    = LG_NUM_GPR'($urandom);
    i.src_a  = LG_NUM_GPR'($urandom);
    i.src_b  = LG_NUM_GPR'($urandom);
    i.flag   = 4'($urandom);
    i.imm    = IMM_W'($urandom);
    return i;
  endfunction

  task automatic drive_side_inputs();
    lce_req   <= rand_req();
    dir       <= rand_dir();
    null_wb   <= 1'($urandom);
    resp_type <= lce_req_type_e'(2'($urandom));
  endtask

  task automatic issue(cce_inst_s next_inst);
    @(posedge clk);
    inst_v <= 1'b1;
    inst   <= next_inst;
    drive_side_inputs();
    strobes_issued++;
  endtask

  // Inputs keep moving while no strobe is present
  task automatic idle(int cycles);
    repeat (cycles) begin
      @(posedge clk);
      inst_v <= 1'b0;
      inst   <= make_inst(opcode_e'(4'($urandom_range(13))));
      drive_side_inputs();
    end
  endtask

  task automatic drain(string what);
    int waited;
    waited = 0;
    while ((strobes_checked != strobes_issued) && (waited < DRAIN_LIMIT)) begin
      @(posedge clk);
      waited++;
    end
    if (strobes_checked != strobes_issued) begin
      $display("Timeout: results of %s were never checked", what);
      $display("Simulation FAILED");
      $finish;
    end
  endtask

  task automatic begin_test();
    test_count++;
    test_err_mark = error_count;
  endtask

  task automatic end_test(string what);
    idle(2);
    drain(what);
    if (error_count == test_err_mark) begin
      $display("test %0d %s: ok", test_count, what);
    end else begin
      $display("test %0d %s: %0d errors", test_count, what, error_count - test_err_mark);
    end
  endtask

  initial begin
    cce_inst_s in;
    void'($urandom(32'h3325));
    reset     = 1'b1;
    inst_v    = 1'b0;
    inst      = '0;
    lce_req   = '0;
    dir       = '0;
    null_wb   = 1'b0;
    resp_type = e_req_rd;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    begin_test();
    idle(12);
    end_test("reset and idle");

    begin_test();
    for (int r = 0; r < NUM_GPR; r++) begin
      in     = make_inst(e_op_movi);
      in.dst = LG_NUM_GPR'(r);
      issue(in);
    end
    repeat (200) begin
      issue(make_inst(opcode_e'(4'($urandom_range(7)))));
    end
    end_test("gpr operations");

    begin_test();
    repeat (60) begin
      issue(make_inst(e_op_ldreq));
      if ($urandom_range(3) == 0) begin
        idle(1);
      end
    end
    end_test("ldreq");

    begin_test();
    repeat (100) begin
      issue(make_inst(e_op_ldreq));
      issue(make_inst(e_op_gad));
    end
    end_test("gad after ldreq");

    begin_test();
    repeat (4) begin
      issue(make_inst(e_op_ldreq));
      issue(make_inst(e_op_gad));
      repeat (20) begin
        case ($urandom_range(2))
          0: issue(make_inst(e_op_sflag));
          1: issue(make_inst(e_op_ldnwb));
          default: begin
            in         = make_inst(e_op_movncs);
            in.imm[2:0] = 3'($urandom_range(4));
            issue(in);
          end
        endcase
      end
      issue(make_inst(e_op_clm));
      idle(2);
    end
    end_test("single field writes and clm");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+sim
common/cce_pkg.sv
design/cce_inst_decode.sv
design/cce_alu.sv
design/cce_dir_flags.sv
cce_reg/cce_reg.sv
design/cce_top.sv
sim/cce_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' flist.f)

.PHONY: run clean

run: obj_dir/Vcce_tb
	@out="$$(./obj_dir/Vcce_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Simulation PASSED$$'

obj_dir/Vcce_tb: flist.f $(SRCS) sim/cce_model.svh
	verilator --binary -Wno-fatal -f flist.f --top-module cce_tb -o Vcce_tb

clean:
	rm -rf obj_dir
